// ==== common/vga_timing_pkg.sv ====
`default_nettype none

package vga_timing_pkg;

  // ----------------------------------------------------------
  // horizontal timing, in system clock cycles
  // ----------------------------------------------------------
  // two cycles per pixel, 640 visible pixels
  localparam int h_active = 1280;
  localparam int h_front  = 32;
  localparam int h_sync   = 192;
  localparam int h_back   = 96;
  // 1600 cycles per line
  localparam int h_total  = h_active + h_front + h_sync + h_back;

  // ----------------------------------------------------------
  // vertical timing, in lines
  // ----------------------------------------------------------
  localparam int v_active = 480;
  localparam int v_front  = 10;
  localparam int v_sync   = 2;
  localparam int v_back   = 33;
  // 525 lines per frame
  localparam int v_total  = v_active + v_front + v_sync + v_back;

  // counter types
  // hcount bits 10:1 are the pixel column
  typedef logic [10:0] hcount_t;
  // one count per line
  typedef logic [9:0]  vcount_t;

endpackage

`default_nettype wire

// ==== common/tile_pkg.sv ====
`default_nettype none

package tile_pkg;

  // ----------------------------------------------------------
  // word and bus types
  // ----------------------------------------------------------
  // one vga color channel, also the bus data width
  typedef logic [7:0]  chan_t;
  // image word, r 15:11, g 10:5, b 4:0
  typedef logic [15:0] rgb565_t;
  typedef logic [10:0] rom_addr_t;
  typedef logic [2:0]  reg_addr_t;
  // pixel source after the tile choice
  typedef logic [1:0]  layer_t;

  // ----------------------------------------------------------
  // tile geometry and image memory layout
  // ----------------------------------------------------------
  localparam int sprite_px = 16;
  localparam int wall_px   = 32;

  // 16x16 images take 256 words, the wall 1024
  localparam rom_addr_t apple_base = 11'd0;
  localparam rom_addr_t head_base  = 11'd256;
  localparam rom_addr_t wall_base  = 11'd512;
  localparam int        rom_depth  = 1536;

  // bus register map
  localparam reg_addr_t reg_sprite_x    = 3'd0;
  localparam reg_addr_t reg_sprite_y    = 3'd1;
  localparam reg_addr_t reg_sprite_kind = 3'd2;

  // sprite kinds, anything else hides the sprite
  localparam chan_t kind_apple = 8'd1;
  localparam chan_t kind_head  = 8'd2;

  // wall border, in 32 pixel tile units
  localparam logic [4:0] wall_col_left   = 5'd0;
  localparam logic [4:0] wall_col_right  = 5'd19;
  localparam logic [4:0] wall_row_top    = 5'd1;
  localparam logic [4:0] wall_row_bottom = 5'd14;

  // layer codes
  localparam layer_t layer_none   = 2'd0;
  localparam layer_t layer_sprite = 2'd1;
  localparam layer_t layer_wall   = 2'd2;

endpackage

`default_nettype wire

// ==== logic/vga_timing.sv ====
`timescale 1ns/10ps
`default_nettype none

module vga_timing
  import vga_timing_pkg::*;
(
  input  logic    clk,
  input  logic    reset,
  output hcount_t hcount,
  output vcount_t vcount,
  output logic    hsync,
  output logic    vsync,
  output logic    blank_n,
  output logic    pixel_clk
);

  logic end_of_line;
  logic end_of_frame;

  // ----------------------------------------------------------
  // counters
  // ----------------------------------------------------------
  assign end_of_line  = (hcount == hcount_t'(h_total - 1));
  assign end_of_frame = (vcount == vcount_t'(v_total - 1));

  // one count per system clock
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      hcount <= '0;
    end else if (end_of_line) begin
      hcount <= '0;
    end else begin
      hcount <= hcount + hcount_t'(1);
    end
  end

  // line counter steps on the horizontal wrap
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      vcount <= '0;
    end else if (end_of_line) begin
      if (end_of_frame) begin
        vcount <= '0;
      end else begin
        vcount <= vcount + vcount_t'(1);
      end
    end
  end

  // ----------------------------------------------------------
  // sync and blanking decode
  // ----------------------------------------------------------
  // hs low for 1312..1503
  assign hsync = !((hcount >= hcount_t'(h_active + h_front)) &&
                   (hcount <  hcount_t'(h_active + h_front + h_sync)));
  // vs low for lines 490..491
  assign vsync = !((vcount >= vcount_t'(v_active + v_front)) &&
                   (vcount <  vcount_t'(v_active + v_front + v_sync)));

  // visible area only
  assign blank_n = (hcount < hcount_t'(h_active)) && (vcount < vcount_t'(v_active));

  // half rate pixel clock, rises mid pixel
  assign pixel_clk = hcount[0];

  // counters never leave the frame
  assert property (@(posedge clk) disable iff (reset)
    (hcount < hcount_t'(h_total)) && (vcount < vcount_t'(v_total)))
    else $error("vga counter out of range");

endmodule

`default_nettype wire

// ==== render/tile_select.sv ====
`timescale 1ns/10ps
`default_nettype none

module tile_select
  import vga_timing_pkg::*, tile_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  chan_t     writedata,
  input  logic      write,
  input  logic      chipselect,
  input  reg_addr_t address,
  input  hcount_t   hcount,
  input  vcount_t   vcount,
  input  logic      hsync,
  input  logic      vsync,
  input  logic      blank_n,
  input  logic      pixel_clk,
  output rom_addr_t rom_addr,
  output layer_t    layer,
  output logic      hsync_d,
  output logic      vsync_d,
  output logic      blank_n_d,
  output logic      pixel_clk_d
);

  chan_t      sprite_x;
  chan_t      sprite_y;
  chan_t      sprite_kind;
  logic [9:0] px_col;
  logic [9:0] px_row;
  logic [4:0] tile_col;
  logic [4:0] tile_row;
  logic       sprite_hit;
  logic       wall_hit;
  rom_addr_t  sprite_base;
  rom_addr_t  addr_next;
  layer_t     layer_next;
  // first pipeline stage
  layer_t     layer_s1;
  logic       hsync_s1;
  logic       vsync_s1;
  logic       blank_n_s1;
  logic       pixel_clk_s1;

  // ----------------------------------------------------------
  // bus registers
  // ----------------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      sprite_x    <= '0;
      sprite_y    <= '0;
      sprite_kind <= '0;
    end else if (chipselect && write) begin
      case (address)
        reg_sprite_x:    sprite_x    <= writedata;
        reg_sprite_y:    sprite_y    <= writedata;
        reg_sprite_kind: sprite_kind <= writedata;
        default: ;
      endcase
    end
  end

  // ----------------------------------------------------------
  // per pixel tile choice
  // ----------------------------------------------------------
  assign px_col   = hcount[10:1];
  assign px_row   = vcount;
  assign tile_col = px_col[9:5];
  assign tile_row = px_row[9:5];

  // 16 pixel cell, only for a known kind
  assign sprite_hit = ((sprite_kind == kind_apple) || (sprite_kind == kind_head)) &&
                      (px_col[9:4] == sprite_x[5:0]) && (px_row[9:4] == sprite_y[5:0]);

  // top and bottom rows full width, side columns under the top row
  assign wall_hit = (tile_row == wall_row_top) || (tile_row == wall_row_bottom) ||
                    (((tile_col == wall_col_left) || (tile_col == wall_col_right)) &&
                     (tile_row > wall_row_top));

  assign sprite_base = (sprite_kind == kind_head) ? head_base : apple_base;

  // sprite over wall, nothing while blanked
  always_comb begin
    if (blank_n && sprite_hit) begin
      layer_next = layer_sprite;
      addr_next  = sprite_base + rom_addr_t'(px_row[3:0]) * rom_addr_t'(sprite_px) +
                   rom_addr_t'(px_col[3:0]);
    end else if (blank_n && wall_hit) begin
      layer_next = layer_wall;
      addr_next  = wall_base + rom_addr_t'(px_row[4:0]) * rom_addr_t'(wall_px) +
                   rom_addr_t'(px_col[4:0]);
    end else begin
      layer_next = layer_none;
      addr_next  = '0;
    end
  end

  // ----------------------------------------------------------
  // stage 1 address, stage 2 delay to meet the rom data
  // ----------------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rom_addr     <= '0;
      layer_s1     <= layer_none;
      hsync_s1     <= 1'b1;
      vsync_s1     <= 1'b1;
      blank_n_s1   <= 1'b0;
      pixel_clk_s1 <= 1'b0;
      layer        <= layer_none;
      hsync_d      <= 1'b1;
      vsync_d      <= 1'b1;
      blank_n_d    <= 1'b0;
      pixel_clk_d  <= 1'b0;
    end else begin
      rom_addr     <= addr_next;
      layer_s1     <= layer_next;
      hsync_s1     <= hsync;
      vsync_s1     <= vsync;
      blank_n_s1   <= blank_n;
      pixel_clk_s1 <= pixel_clk;
      layer        <= layer_s1;
      hsync_d      <= hsync_s1;
      vsync_d      <= vsync_s1;
      blank_n_d    <= blank_n_s1;
      pixel_clk_d  <= pixel_clk_s1;
    end
  end

  // a sprite pixel came from a valid kind two cycles back
  assert property (@(posedge clk) disable iff (reset)
    (layer == layer_sprite) |->
      (($past(sprite_kind, 2) == kind_apple) || ($past(sprite_kind, 2) == kind_head)))
    else $error("sprite layer with unknown kind");

endmodule

`default_nettype wire

// ==== render/tile_rom.sv ====
`timescale 1ns/10ps
`default_nettype none

module tile_rom
  import tile_pkg::*;
(
  input  logic      clk,
  input  rom_addr_t rom_addr,
  output rgb565_t   rom_data
);

  // ----------------------------------------------------------
  // image memory
  // ----------------------------------------------------------
  // apple at 0, head at 256, wall at 512
  rgb565_t mem [rom_depth];

  // images come from the data file
  initial begin
    $readmemh("render/tiles.hex", mem);
  end

  // one cycle read, data lines up with the delayed layer
  always_ff @(posedge clk) begin
    rom_data <= mem[rom_addr];
  end

  // tile_select never points past the wall image
  assert property (@(posedge clk) rom_addr < rom_addr_t'(rom_depth))
    else $error("image address out of range");

endmodule

`default_nettype wire

// ==== render/pixel_out.sv ====
`timescale 1ns/10ps
`default_nettype none

module pixel_out
  import tile_pkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  rgb565_t rom_data,
  input  layer_t  layer,
  input  logic    hsync_d,
  input  logic    vsync_d,
  input  logic    blank_n_d,
  input  logic    pixel_clk_d,
  output chan_t   VGA_R,
  output chan_t   VGA_G,
  output chan_t   VGA_B,
  output logic    VGA_HS,
  output logic    VGA_VS,
  output logic    VGA_BLANK_n,
  output logic    VGA_CLK
);

  chan_t red_next;
  chan_t green_next;
  chan_t blue_next;

  // ----------------------------------------------------------
  // rgb565 to 8 bits per channel, low bits zero
  // ----------------------------------------------------------
  always_comb begin
    if (layer == layer_none) begin
      // black background and blanking
      red_next   = '0;
      green_next = '0;
      blue_next  = '0;
    end else begin
      red_next   = {rom_data[15:11], 3'b000};
      green_next = {rom_data[10:5], 2'b00};
      blue_next  = {rom_data[4:0], 3'b000};
    end
  end

  // output register, colors and controls leave together
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      VGA_R       <= '0;
      VGA_G       <= '0;
      VGA_B       <= '0;
      VGA_HS      <= 1'b1;
      VGA_VS      <= 1'b1;
      VGA_BLANK_n <= 1'b0;
      VGA_CLK     <= 1'b0;
    end else begin
      VGA_R       <= red_next;
      VGA_G       <= green_next;
      VGA_B       <= blue_next;
      VGA_HS      <= hsync_d;
      VGA_VS      <= vsync_d;
      VGA_BLANK_n <= blank_n_d;
      VGA_CLK     <= pixel_clk_d;
    end
  end

  // blanking upstream must come back as black here
  assert property (@(posedge clk) disable iff (reset)
    !VGA_BLANK_n |-> ((VGA_R == '0) && (VGA_G == '0) && (VGA_B == '0)))
    else $error("color during blanking");

endmodule

`default_nettype wire

// ==== logic/vga_tiles.sv ====
`timescale 1ns/10ps
`default_nettype none

module vga_tiles
  import vga_timing_pkg::*, tile_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  chan_t     writedata,
  input  logic      write,
  input  logic      chipselect,
  input  reg_addr_t address,
  output chan_t     VGA_R,
  output chan_t     VGA_G,
  output chan_t     VGA_B,
  output logic      VGA_CLK,
  output logic      VGA_HS,
  output logic      VGA_VS,
  output logic      VGA_BLANK_n,
  output logic      VGA_SYNC_n
);

  // raw timing, cycle 0
  hcount_t   hcount;
  vcount_t   vcount;
  logic      hsync;
  logic      vsync;
  logic      blank_n;
  logic      pixel_clk;

  // aligned with rom data, cycle 2
  rom_addr_t rom_addr;
  rgb565_t   rom_data;
  layer_t    layer;
  logic      hsync_d;
  logic      vsync_d;
  logic      blank_n_d;
  logic      pixel_clk_d;

  // ----------------------------------------------------------
  // producer, buffer, consumer
  // ----------------------------------------------------------
  vga_timing timing (.*);

  tile_select select (.*);

  tile_rom rom (.*);

  pixel_out out (.*);

  // sync on green unused
  assign VGA_SYNC_n = 1'b0;

endmodule

`default_nettype wire

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic reset
);

  // 4 ns period
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // reset for 5 cycles, released on a falling edge
  initial begin
    reset = 1'b1;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule

`default_nettype wire

// ==== verif/vga_tiles_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module vga_tiles_tb
  import vga_timing_pkg::*, tile_pkg::*;
;

  localparam int frame_cycles   = h_total * v_total;
  // four frames are run, one spare
  localparam int timeout_cycles = 5 * frame_cycles;

  logic clk;
  logic reset;
  chan_t writedata;
  logic write;
  logic chipselect;
  reg_addr_t address;
  chan_t VGA_R;
  chan_t VGA_G;
  chan_t VGA_B;
  logic VGA_CLK;
  logic VGA_HS;
  logic VGA_VS;
  logic VGA_BLANK_n;
  logic VGA_SYNC_n;

  // model state
  rgb565_t image [rom_depth];
  chan_t mx;
  chan_t my;
  chan_t mkind;
  int mh;
  int mv;
  int frame;
  int cycles;
  int color_errors;
  int control_errors;
  logic [31:0] lfsr;
  string test_name;
  // expected outputs, index 0 newest
  chan_t exp_r [3];
  chan_t exp_g [3];
  chan_t exp_b [3];
  logic exp_hs [3];
  logic exp_vs [3];
  logic exp_blank [3];
  logic exp_clk [3];
  // pending bus writes
  int q_addr [$];
  int q_data [$];
  bit q_cs [$];

  tb_clock_gen clock_gen (.clk(clk), .reset(reset));

  vga_tiles UUT (.*);

  // ----------------------------------------------------------
  // helpers
  // ----------------------------------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) return (s >> 1) ^ 32'h80200003;
    else return s >> 1;
  endfunction

  // one lfsr step per bit
  task automatic random_bits(input int n, output int value);
    int i;
    value = 0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      value = (value << 1) | int'(lfsr[0]);
    end
  endtask

  task automatic queue_write(input int a, input int d, input bit cs);
    q_addr.push_back(a);
    q_data.push_back(d);
    q_cs.push_back(cs);
  endtask

  // image word for a counter position, -1 for black
  function automatic int expected_word(input int hc, input int vc);
    int col;
    int row;
    int tc;
    int tr;
    int base;
    col = hc / 2;
    row = vc;
    tc = col / 32;
    tr = row / 32;
    if (hc >= h_active || vc >= v_active) return -1;
    if ((mkind == kind_apple || mkind == kind_head) &&
        col / 16 == int'(mx) % 64 && row / 16 == int'(my) % 64) begin
      base = (mkind == kind_head) ? 256 : 0;
      return int'(image[rom_addr_t'(base + (row % 16) * 16 + col % 16)]);
    end
    if (tr == 1 || tr == 14 || ((tc == 0 || tc == 19) && tr > 1))
      return int'(image[rom_addr_t'(512 + (row % 32) * 32 + col % 32)]);
    return -1;
  endfunction

  task automatic check_chan(input string name, input chan_t expected, input chan_t actual);
    if (expected !== actual) begin
      color_errors++;
      if (color_errors <= 20)
        $display("Mismatch %s cycle %0d: expected %h, actual %h",
                 name, cycles, expected, actual);
    end
  endtask

  task automatic check_level(input string name, input logic expected, input logic actual);
    if (expected !== actual) begin
      control_errors++;
      if (control_errors <= 20)
        $display("Mismatch %s cycle %0d: expected %b, actual %b",
                 name, cycles, expected, actual);
    end
  endtask

  // writes for the frame after this one
  task automatic plan_frame_writes(input int done_frame);
    int x;
    int y;
    int k;
    random_bits(6, x);
    random_bits(5, y);
    x = x % 40;
    y = y % 30;
    if (done_frame == 0) begin
      // apple on a wall row, cells 2, 3, 28 or 29
      random_bits(2, k);
      y = (k < 2) ? 2 + k : 26 + k;
    end
    if (done_frame == 0 || done_frame == 1) begin
      queue_write(int'(reg_sprite_x), x, 1'b1);
      queue_write(int'(reg_sprite_y), y, 1'b1);
      queue_write(int'(reg_sprite_kind), (done_frame == 0) ? 1 : 2, 1'b1);
    end else if (done_frame == 2) begin
      random_bits(8, k);
      if (k == 1 || k == 2) k = k + 2;
      queue_write(int'(reg_sprite_kind), k, 1'b1);
      // deselected, must be ignored
      queue_write(int'(reg_sprite_kind), 1, 1'b0);
      queue_write(int'(reg_sprite_x), x, 1'b0);
    end
  endtask

  // ----------------------------------------------------------
  // cycle counter and timeout
  // ----------------------------------------------------------
  always @(posedge clk) begin
    cycles++;
    if (cycles >= timeout_cycles) begin
      $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display("Done: errors found");
      $finish;
    end
  end

  // ----------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------
  initial begin
    int i;
    int w;
    writedata = '0;
    write = 1'b0;
    chipselect = 1'b0;
    address = '0;
    cycles = 0;
    color_errors = 0;
    control_errors = 0;
    lfsr = 32'h39f425ba;
    mx = '0;
    my = '0;
    mkind = '0;
    mh = 0;
    mv = 0;
    frame = 0;
    $readmemh("render/tiles.hex", image);
    // pipeline starts from reset values
    for (i = 0; i < 3; i++) begin
      exp_r[i] = '0;
      exp_g[i] = '0;
      exp_b[i] = '0;
      exp_hs[i] = 1'b1;
      exp_vs[i] = 1'b1;
      exp_blank[i] = 1'b0;
      exp_clk[i] = 1'b0;
    end
    // outputs during reset
    test_name = "reset";
    @(negedge clk);
    check_chan("reset R", '0, VGA_R);
    check_chan("reset G", '0, VGA_G);
    check_chan("reset B", '0, VGA_B);
    check_level("reset BLANK_n", 1'b0, VGA_BLANK_n);
    check_level("reset HS", 1'b1, VGA_HS);
    check_level("reset VS", 1'b1, VGA_VS);
    check_level("reset SYNC_n", 1'b0, VGA_SYNC_n);
    @(negedge reset);
    test_name = "walls";
    while (frame < 4) begin
      check_chan({test_name, " R"}, exp_r[2], VGA_R);
      check_chan({test_name, " G"}, exp_g[2], VGA_G);
      check_chan({test_name, " B"}, exp_b[2], VGA_B);
      check_level({test_name, " HS"}, exp_hs[2], VGA_HS);
      check_level({test_name, " VS"}, exp_vs[2], VGA_VS);
      check_level({test_name, " BLANK_n"}, exp_blank[2], VGA_BLANK_n);
      check_level({test_name, " CLK"}, exp_clk[2], VGA_CLK);
      check_level({test_name, " SYNC_n"}, 1'b0, VGA_SYNC_n);
      if (!VGA_BLANK_n) begin
        check_chan("blank R", '0, VGA_R);
        check_chan("blank G", '0, VGA_G);
        check_chan("blank B", '0, VGA_B);
      end
      for (i = 2; i > 0; i--) begin
        exp_r[i] = exp_r[i-1];
        exp_g[i] = exp_g[i-1];
        exp_b[i] = exp_b[i-1];
        exp_hs[i] = exp_hs[i-1];
        exp_vs[i] = exp_vs[i-1];
        exp_blank[i] = exp_blank[i-1];
        exp_clk[i] = exp_clk[i-1];
      end
      w = expected_word(mh, mv);
      if (w < 0) w = 0;
      exp_r[0] = {w[15:11], 3'b000};
      exp_g[0] = {w[10:5], 2'b00};
      exp_b[0] = {w[4:0], 3'b000};
      exp_hs[0] = !(mh >= 1312 && mh < 1504);
      exp_vs[0] = !(mv >= 490 && mv < 492);
      exp_blank[0] = (mh < 1280) && (mv < 480);
      exp_clk[0] = (mh % 2) == 1;
      // bus, only inside vertical sync
      if (!VGA_VS && q_addr.size() > 0) begin
        address = reg_addr_t'(q_addr.pop_front());
        writedata = chan_t'(q_data.pop_front());
        chipselect = q_cs.pop_front();
        write = 1'b1;
      end else begin
        address = '0;
        writedata = '0;
        chipselect = 1'b0;
        write = 1'b0;
      end
      if (chipselect && write) begin
        if (address == reg_sprite_x) mx = writedata;
        else if (address == reg_sprite_y) my = writedata;
        else if (address == reg_sprite_kind) mkind = writedata;
      end
      // model counters
      mh++;
      if (mh == h_total) begin
        mh = 0;
        mv++;
        if (mv == v_total) begin
          mv = 0;
          frame++;
          if (frame == 1) test_name = "apple";
          else if (frame == 2) test_name = "head";
          else test_name = "no_sprite";
        end
      end
      if (mh == 0 && mv == v_active) plan_frame_writes(frame);
      @(negedge clk);
    end
    $display("color errors: %0d, control errors: %0d", color_errors, control_errors);
    if (color_errors == 0 && control_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== render/tiles.hex ====
// one rgb565 word per column, 24 per line; apple at 0, head at 256, wall at 512
F800 F801 F802 F803 F804 F805 F806 F807 F808 F809 F80A F80B F80C F80D F80E F80F F810 F811 F812 F813 F814 F815 F816 F817
F818 F819 F81A F81B F81C F81D F81E F81F F820 F821 F822 F823 F824 F825 F826 F827 F828 F829 F82A F82B F82C F82D F82E F82F
F830 F831 F832 F833 F834 F835 F836 F837 F838 F839 F83A F83B F83C F83D F83E F83F F840 F841 F842 F843 F844 F845 F846 F847
F848 F849 F84A F84B F84C F84D F84E F84F F850 F851 F852 F853 F854 F855 F856 F857 F858 F859 F85A F85B F85C F85D F85E F85F
F860 F861 F862 F863 F864 F865 F866 F867 F868 F869 F86A F86B F86C F86D F86E F86F F870 F871 F872 F873 F874 F875 F876 F877
F878 F879 F87A F87B F87C F87D F87E F87F F880 F881 F882 F883 F884 F885 F886 F887 F888 F889 F88A F88B F88C F88D F88E F88F
F890 F891 F892 F893 F894 F895 F896 F897 F898 F899 F89A F89B F89C F89D F89E F89F F8A0 F8A1 F8A2 F8A3 F8A4 F8A5 F8A6 F8A7
F8A8 F8A9 F8AA F8AB F8AC F8AD F8AE F8AF F8B0 F8B1 F8B2 F8B3 F8B4 F8B5 F8B6 F8B7 F8B8 F8B9 F8BA F8BB F8BC F8BD F8BE F8BF
F8C0 F8C1 F8C2 F8C3 F8C4 F8C5 F8C6 F8C7 F8C8 F8C9 F8CA F8CB F8CC F8CD F8CE F8CF F8D0 F8D1 F8D2 F8D3 F8D4 F8D5 F8D6 F8D7
F8D8 F8D9 F8DA F8DB F8DC F8DD F8DE F8DF F8E0 F8E1 F8E2 F8E3 F8E4 F8E5 F8E6 F8E7 F8E8 F8E9 F8EA F8EB F8EC F8ED F8EE F8EF
F8F0 F8F1 F8F2 F8F3 F8F4 F8F5 F8F6 F8F7 F8F8 F8F9 F8FA F8FB F8FC F8FD F8FE F8FF 2100 2101 2102 2103 2104 2105 2106 2107
2108 2109 210A 210B 210C 210D 210E 210F 2110 2111 2112 2113 2114 2115 2116 2117 2118 2119 211A 211B 211C 211D 211E 211F
2120 2121 2122 2123 2124 2125 2126 2127 2128 2129 212A 212B 212C 212D 212E 212F 2130 2131 2132 2133 2134 2135 2136 2137
2138 2139 213A 213B 213C 213D 213E 213F 2140 2141 2142 2143 2144 2145 2146 2147 2148 2149 214A 214B 214C 214D 214E 214F
2150 2151 2152 2153 2154 2155 2156 2157 2158 2159 215A 215B 215C 215D 215E 215F 2160 2161 2162 2163 2164 2165 2166 2167
2168 2169 216A 216B 216C 216D 216E 216F 2170 2171 2172 2173 2174 2175 2176 2177 2178 2179 217A 217B 217C 217D 217E 217F
2180 2181 2182 2183 2184 2185 2186 2187 2188 2189 218A 218B 218C 218D 218E 218F 2190 2191 2192 2193 2194 2195 2196 2197
2198 2199 219A 219B 219C 219D 219E 219F 21A0 21A1 21A2 21A3 21A4 21A5 21A6 21A7 21A8 21A9 21AA 21AB 21AC 21AD 21AE 21AF
21B0 21B1 21B2 21B3 21B4 21B5 21B6 21B7 21B8 21B9 21BA 21BB 21BC 21BD 21BE 21BF 21C0 21C1 21C2 21C3 21C4 21C5 21C6 21C7
21C8 21C9 21CA 21CB 21CC 21CD 21CE 21CF 21D0 21D1 21D2 21D3 21D4 21D5 21D6 21D7 21D8 21D9 21DA 21DB 21DC 21DD 21DE 21DF
21E0 21E1 21E2 21E3 21E4 21E5 21E6 21E7 21E8 21E9 21EA 21EB 21EC 21ED 21EE 21EF 21F0 21F1 21F2 21F3 21F4 21F5 21F6 21F7
21F8 21F9 21FA 21FB 21FC 21FD 21FE 21FF 9200 9201 9202 9203 9204 9205 9206 9207 9208 9209 920A 920B 920C 920D 920E 920F
9210 9211 9212 9213 9214 9215 9216 9217 9218 9219 921A 921B 921C 921D 921E 921F 9220 9221 9222 9223 9224 9225 9226 9227
9228 9229 922A 922B 922C 922D 922E 922F 9230 9231 9232 9233 9234 9235 9236 9237 9238 9239 923A 923B 923C 923D 923E 923F
9240 9241 9242 9243 9244 9245 9246 9247 9248 9249 924A 924B 924C 924D 924E 924F 9250 9251 9252 9253 9254 9255 9256 9257
9258 9259 925A 925B 925C 925D 925E 925F 9260 9261 9262 9263 9264 9265 9266 9267 9268 9269 926A 926B 926C 926D 926E 926F
9270 9271 9272 9273 9274 9275 9276 9277 9278 9279 927A 927B 927C 927D 927E 927F 9280 9281 9282 9283 9284 9285 9286 9287
9288 9289 928A 928B 928C 928D 928E 928F 9290 9291 9292 9293 9294 9295 9296 9297 9298 9299 929A 929B 929C 929D 929E 929F
92A0 92A1 92A2 92A3 92A4 92A5 92A6 92A7 92A8 92A9 92AA 92AB 92AC 92AD 92AE 92AF 92B0 92B1 92B2 92B3 92B4 92B5 92B6 92B7
92B8 92B9 92BA 92BB 92BC 92BD 92BE 92BF 92C0 92C1 92C2 92C3 92C4 92C5 92C6 92C7 92C8 92C9 92CA 92CB 92CC 92CD 92CE 92CF
92D0 92D1 92D2 92D3 92D4 92D5 92D6 92D7 92D8 92D9 92DA 92DB 92DC 92DD 92DE 92DF 92E0 92E1 92E2 92E3 92E4 92E5 92E6 92E7
92E8 92E9 92EA 92EB 92EC 92ED 92EE 92EF 92F0 92F1 92F2 92F3 92F4 92F5 92F6 92F7 92F8 92F9 92FA 92FB 92FC 92FD 92FE 92FF
9300 9301 9302 9303 9304 9305 9306 9307 9308 9309 930A 930B 930C 930D 930E 930F 9310 9311 9312 9313 9314 9315 9316 9317
9318 9319 931A 931B 931C 931D 931E 931F 9320 9321 9322 9323 9324 9325 9326 9327 9328 9329 932A 932B 932C 932D 932E 932F
9330 9331 9332 9333 9334 9335 9336 9337 9338 9339 933A 933B 933C 933D 933E 933F 9340 9341 9342 9343 9344 9345 9346 9347
9348 9349 934A 934B 934C 934D 934E 934F 9350 9351 9352 9353 9354 9355 9356 9357 9358 9359 935A 935B 935C 935D 935E 935F
9360 9361 9362 9363 9364 9365 9366 9367 9368 9369 936A 936B 936C 936D 936E 936F 9370 9371 9372 9373 9374 9375 9376 9377
9378 9379 937A 937B 937C 937D 937E 937F 9380 9381 9382 9383 9384 9385 9386 9387 9388 9389 938A 938B 938C 938D 938E 938F
9390 9391 9392 9393 9394 9395 9396 9397 9398 9399 939A 939B 939C 939D 939E 939F 93A0 93A1 93A2 93A3 93A4 93A5 93A6 93A7
93A8 93A9 93AA 93AB 93AC 93AD 93AE 93AF 93B0 93B1 93B2 93B3 93B4 93B5 93B6 93B7 93B8 93B9 93BA 93BB 93BC 93BD 93BE 93BF
93C0 93C1 93C2 93C3 93C4 93C5 93C6 93C7 93C8 93C9 93CA 93CB 93CC 93CD 93CE 93CF 93D0 93D1 93D2 93D3 93D4 93D5 93D6 93D7
93D8 93D9 93DA 93DB 93DC 93DD 93DE 93DF 93E0 93E1 93E2 93E3 93E4 93E5 93E6 93E7 93E8 93E9 93EA 93EB 93EC 93ED 93EE 93EF
93F0 93F1 93F2 93F3 93F4 93F5 93F6 93F7 93F8 93F9 93FA 93FB 93FC 93FD 93FE 93FF 9400 9401 9402 9403 9404 9405 9406 9407
9408 9409 940A 940B 940C 940D 940E 940F 9410 9411 9412 9413 9414 9415 9416 9417 9418 9419 941A 941B 941C 941D 941E 941F
9420 9421 9422 9423 9424 9425 9426 9427 9428 9429 942A 942B 942C 942D 942E 942F 9430 9431 9432 9433 9434 9435 9436 9437
9438 9439 943A 943B 943C 943D 943E 943F 9440 9441 9442 9443 9444 9445 9446 9447 9448 9449 944A 944B 944C 944D 944E 944F
9450 9451 9452 9453 9454 9455 9456 9457 9458 9459 945A 945B 945C 945D 945E 945F 9460 9461 9462 9463 9464 9465 9466 9467
9468 9469 946A 946B 946C 946D 946E 946F 9470 9471 9472 9473 9474 9475 9476 9477 9478 9479 947A 947B 947C 947D 947E 947F
9480 9481 9482 9483 9484 9485 9486 9487 9488 9489 948A 948B 948C 948D 948E 948F 9490 9491 9492 9493 9494 9495 9496 9497
9498 9499 949A 949B 949C 949D 949E 949F 94A0 94A1 94A2 94A3 94A4 94A5 94A6 94A7 94A8 94A9 94AA 94AB 94AC 94AD 94AE 94AF
94B0 94B1 94B2 94B3 94B4 94B5 94B6 94B7 94B8 94B9 94BA 94BB 94BC 94BD 94BE 94BF 94C0 94C1 94C2 94C3 94C4 94C5 94C6 94C7
94C8 94C9 94CA 94CB 94CC 94CD 94CE 94CF 94D0 94D1 94D2 94D3 94D4 94D5 94D6 94D7 94D8 94D9 94DA 94DB 94DC 94DD 94DE 94DF
94E0 94E1 94E2 94E3 94E4 94E5 94E6 94E7 94E8 94E9 94EA 94EB 94EC 94ED 94EE 94EF 94F0 94F1 94F2 94F3 94F4 94F5 94F6 94F7
94F8 94F9 94FA 94FB 94FC 94FD 94FE 94FF 9500 9501 9502 9503 9504 9505 9506 9507 9508 9509 950A 950B 950C 950D 950E 950F
9510 9511 9512 9513 9514 9515 9516 9517 9518 9519 951A 951B 951C 951D 951E 951F 9520 9521 9522 9523 9524 9525 9526 9527
9528 9529 952A 952B 952C 952D 952E 952F 9530 9531 9532 9533 9534 9535 9536 9537 9538 9539 953A 953B 953C 953D 953E 953F
9540 9541 9542 9543 9544 9545 9546 9547 9548 9549 954A 954B 954C 954D 954E 954F 9550 9551 9552 9553 9554 9555 9556 9557
9558 9559 955A 955B 955C 955D 955E 955F 9560 9561 9562 9563 9564 9565 9566 9567 9568 9569 956A 956B 956C 956D 956E 956F
9570 9571 9572 9573 9574 9575 9576 9577 9578 9579 957A 957B 957C 957D 957E 957F 9580 9581 9582 9583 9584 9585 9586 9587
9588 9589 958A 958B 958C 958D 958E 958F 9590 9591 9592 9593 9594 9595 9596 9597 9598 9599 959A 959B 959C 959D 959E 959F
95A0 95A1 95A2 95A3 95A4 95A5 95A6 95A7 95A8 95A9 95AA 95AB 95AC 95AD 95AE 95AF 95B0 95B1 95B2 95B3 95B4 95B5 95B6 95B7
95B8 95B9 95BA 95BB 95BC 95BD 95BE 95BF 95C0 95C1 95C2 95C3 95C4 95C5 95C6 95C7 95C8 95C9 95CA 95CB 95CC 95CD 95CE 95CF
95D0 95D1 95D2 95D3 95D4 95D5 95D6 95D7 95D8 95D9 95DA 95DB 95DC 95DD 95DE 95DF 95E0 95E1 95E2 95E3 95E4 95E5 95E6 95E7
95E8 95E9 95EA 95EB 95EC 95ED 95EE 95EF 95F0 95F1 95F2 95F3 95F4 95F5 95F6 95F7 95F8 95F9 95FA 95FB 95FC 95FD 95FE 95FF

// ==== vlog.f ====
common/vga_timing_pkg.sv
common/tile_pkg.sv
logic/vga_timing.sv
render/tile_select.sv
render/tile_rom.sv
render/pixel_out.sv
logic/vga_tiles.sv
verif/tb_clock_gen.sv
verif/vga_tiles_tb.sv

// ==== Makefile ====
SIM = obj_dir/Vvga_tiles_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module vga_tiles_tb -Mdir obj_dir -f vlog.f

# pass only when the pass line is printed
run: compile
	./$(SIM) | tee /dev/stderr | grep -q "^Done: no errors$$"

clean:
	rm -rf obj_dir
